//--- hyper_ctrl_pkg.sv
// widths, timing constants and memory-select codes of the hyperbus transaction controller
package hyper_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////////////////////

    // transfer size in bytes, also used for burst and remaining beat counts
    localparam int SIZE_WIDTH     = 16;
    localparam int ADDR_WIDTH     = 32; // byte address
    localparam int RECOVERY_WIDTH = 8;  // read-write recovery time in cycles
    localparam int MASK_WIDTH     = 2;  // one bit per byte of a 16-bit beat
    localparam int NR_CS          = 2;  // flash and ram chip selects
    localparam int MEM_SEL_WIDTH  = 2;

    ////////////////////////////////////////////////////////////////////////////
    // memory select
    ////////////////////////////////////////////////////////////////////////////

    // every code other than hyperflash selects hyperram
    localparam logic [MEM_SEL_WIDTH-1:0] MEM_SEL_FLASH = 2'b01;

    ////////////////////////////////////////////////////////////////////////////
    // timing
    ////////////////////////////////////////////////////////////////////////////

    // wait after a register-space write is handed to the phy
    localparam logic [RECOVERY_WIDTH-1:0] T_REG_W = 8'd4;

    // recovery time until the first request sets its own
    localparam logic [RECOVERY_WIDTH-1:0] T_RW_RECOVERY_RST = 8'd6;

endpackage

//--- hyper_txn_if.sv
// captured transaction and progress strobes shared by the controller submodules
`timescale 1ns/1ps

interface hyper_txn_if;
    import hyper_ctrl_pkg::*;

    // captured request
    logic [SIZE_WIDTH-1:0] size;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  rw;       // 1: read, 0: write

    // progress strobes from the fsm
    logic                  setup;    // state is SETUP
    logic                  load;     // SETUP of a memory transaction
    logic                  xfer;     // read or write transfer state
    logic                  idle;
    logic                  finish;   // state is END

    // beat progress from the counter
    logic                  beat;     // handshake of the active direction
    logic [SIZE_WIDTH-1:0] remaining;
    logic                  done;

    modport fsm_mp (
        output size, addr, rw, setup, load, xfer, idle, finish,
        input  done
    );

    modport counter_mp (
        input  size, addr, rw, load, xfer, finish,
        output beat, remaining, done
    );

    modport mask_mp (
        input  size, addr, rw, setup, idle, beat, remaining
    );

endinterface

//--- hyper_txn_fsm.sv
// request capture, controller fsm, register-write wait, recovery counter and chip-select decode
`timescale 1ns/1ps

module hyper_txn_fsm
(
    input  logic                                        clk_i,
    input  logic                                        rst_ni,

    // request port
    input  logic                                        trans_valid_i,
    output logic                                        trans_ready_o,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       size_i,
    input  logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       addr_i,
    input  logic                                        rw_i,
    input  logic                                        addr_space_i,
    input  logic [hyper_ctrl_pkg::MEM_SEL_WIDTH-1:0]    mem_sel_i,
    input  logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   t_rw_recovery_i,

    // phy handover
    output logic                                        phy_trans_valid_o,
    input  logic                                        phy_trans_ready_i,

    // captured request
    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       ctrl_size_o,
    output logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       ctrl_addr_o,
    output logic                                        ctrl_rw_o,
    output logic                                        ctrl_addr_space_o,
    output logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   ctrl_t_rw_recovery_o,

    output logic [hyper_ctrl_pkg::NR_CS-1:0]            trans_cs_o,

    hyper_txn_if.fsm_mp                                 txn
);
    import hyper_ctrl_pkg::*;

    enum logic [2:0] {IDLE, SETUP, REG_W, READ, WRITE, END} state_q;

    logic [SIZE_WIDTH-1:0]     r_size;
    logic [ADDR_WIDTH-1:0]     r_addr;
    logic                      r_rw;
    logic                      r_addr_space;
    logic [MEM_SEL_WIDTH-1:0]  r_mem_sel;
    logic [RECOVERY_WIDTH-1:0] r_t_rw_recovery;

    logic [RECOVERY_WIDTH-1:0] cnt_reg_w;
    logic [RECOVERY_WIDTH-1:0] cnt_rw_recovery;
    logic [RECOVERY_WIDTH-1:0] recovery_start;
    logic                      accept;
    logic                      handover;
    logic                      reg_write;

    assign accept    = trans_valid_i & trans_ready_o;
    assign handover  = phy_trans_valid_o & phy_trans_ready_i;
    assign reg_write = r_addr_space & ~r_rw; // register-space write, no data phase

    // END takes the recovery time, but never less than one cycle
    assign recovery_start = (r_t_rw_recovery > RECOVERY_WIDTH'(1)) ?
                            r_t_rw_recovery - RECOVERY_WIDTH'(1) : '0;

    ////////////////////////////////////////////////////////////////////////////
    // request capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            r_size          <= '0;
            r_addr          <= '0;
            r_rw            <= 1'b0;
            r_addr_space    <= 1'b0;
            r_mem_sel       <= '0;
            r_t_rw_recovery <= T_RW_RECOVERY_RST;
        end
        else if (accept)
        begin
            r_size          <= size_i;
            r_addr          <= addr_i;
            r_rw            <= rw_i;
            r_addr_space    <= addr_space_i;
            r_mem_sel       <= mem_sel_i;
            r_t_rw_recovery <= t_rw_recovery_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // controller state machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q           <= IDLE;
            trans_ready_o     <= 1'b1;
            phy_trans_valid_o <= 1'b0;
            cnt_reg_w         <= '0;
            cnt_rw_recovery   <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (accept)
                    begin
                        state_q       <= SETUP;
                        trans_ready_o <= 1'b0;
                    end
                    else
                        trans_ready_o <= 1'b1;
                end
                SETUP:
                begin
                    phy_trans_valid_o <= 1'b1; // held until END
                    if (handover)
                    begin
                        if (reg_write)
                        begin
                            cnt_reg_w <= T_REG_W + RECOVERY_WIDTH'(1);
                            state_q   <= REG_W;
                        end
                        else if (r_rw)
                            state_q <= READ;
                        else
                            state_q <= WRITE;
                    end
                end
                REG_W:
                begin
                    if (cnt_reg_w == '0)
                    begin
                        state_q           <= END;
                        phy_trans_valid_o <= 1'b0;
                        cnt_rw_recovery   <= recovery_start;
                    end
                    else
                        cnt_reg_w <= cnt_reg_w - RECOVERY_WIDTH'(1);
                end
                READ, WRITE:
                begin
                    if (txn.done) // last beat has moved
                    begin
                        state_q           <= END;
                        phy_trans_valid_o <= 1'b0;
                        cnt_rw_recovery   <= recovery_start;
                    end
                end
                END:
                begin
                    if (cnt_rw_recovery == '0)
                        state_q <= IDLE;
                    else
                        cnt_rw_recovery <= cnt_rw_recovery - RECOVERY_WIDTH'(1);
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // progress strobes
    assign txn.setup  = (state_q == SETUP);
    assign txn.load   = (state_q == SETUP) & ~reg_write;
    assign txn.xfer   = (state_q == READ) | (state_q == WRITE);
    assign txn.idle   = (state_q == IDLE);
    assign txn.finish = (state_q == END);

    assign txn.size = r_size;
    assign txn.addr = r_addr;
    assign txn.rw   = r_rw;

    assign ctrl_size_o          = r_size;
    assign ctrl_addr_o          = r_addr;
    assign ctrl_rw_o            = r_rw;
    assign ctrl_addr_space_o    = r_addr_space;
    assign ctrl_t_rw_recovery_o = r_t_rw_recovery;

    // chip select from the captured memory select
    assign trans_cs_o[0] = (r_mem_sel == MEM_SEL_FLASH);  // hyperflash
    assign trans_cs_o[1] = (r_mem_sel != MEM_SEL_FLASH);  // hyperram

endmodule

//--- hyper_beat_counter.sv
// burst length in 16-bit beats and count of the beats still to move
`timescale 1ns/1ps

module hyper_beat_counter
(
    input  logic                                    clk_i,
    input  logic                                    rst_ni,

    // phy data handshakes
    input  logic                                    rx_valid_phy_i,
    input  logic                                    rx_ready_phy_i,
    input  logic                                    tx_valid_phy_i,
    input  logic                                    tx_ready_phy_i,

    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]   trans_burst_o,
    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]   remained_data_o,
    output logic                                    odd_start_o,

    hyper_txn_if.counter_mp                         txn
);
    import hyper_ctrl_pkg::*;

    logic [SIZE_WIDTH-1:0] burst_len;
    logic                  extra_beat;
    logic                  rx_beat;
    logic                  tx_beat;

    assign odd_start_o = txn.addr[0]; // transfer starts on the upper byte

    // a partial beat at either end costs one more beat
    assign extra_beat = txn.size[0] | txn.addr[0];
    assign burst_len  = (txn.size >> 1) + SIZE_WIDTH'(extra_beat);

    assign rx_beat  = rx_valid_phy_i & rx_ready_phy_i;
    assign tx_beat  = tx_valid_phy_i & tx_ready_phy_i;
    assign txn.beat = txn.xfer & (txn.rw ? rx_beat : tx_beat);

    assign txn.remaining = remained_data_o;
    assign txn.done      = (remained_data_o == '0);

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            trans_burst_o   <= '0;
            remained_data_o <= '0;
        end
        else if (txn.finish)
        begin
            trans_burst_o   <= '0;
            remained_data_o <= '0;
        end
        else if (txn.load)
        begin
            trans_burst_o   <= burst_len;
            remained_data_o <= burst_len;
        end
        else if (txn.beat && !txn.done)
            remained_data_o <= remained_data_o - SIZE_WIDTH'(1);
    end

endmodule

//--- hyper_mask_gen.sv
// head and tail byte masks for hyperbus write bursts
`timescale 1ns/1ps

module hyper_mask_gen
(
    input  logic                                    clk_i,
    input  logic                                    rst_ni,

    output logic [hyper_ctrl_pkg::MASK_WIDTH-1:0]   data_mask_o,

    hyper_txn_if.mask_mp                            txn
);
    import hyper_ctrl_pkg::*;

    logic [MASK_WIDTH-1:0] head_mask;
    logic [MASK_WIDTH-1:0] tail_mask;
    logic                  tail_odd;
    logic                  write_beat;

    ////////////////////////////////////////////////////////////////////////////
    // mask rules
    ////////////////////////////////////////////////////////////////////////////

    // odd start drops the lower byte, a single byte drops the upper one
    assign head_mask = txn.addr[0]                   ? 2'b01 :
                       (txn.size == SIZE_WIDTH'(1))  ? 2'b10 : 2'b00;

    // bit 0 of addr[1:0] + size[1:0], burst ends on the lower byte
    assign tail_odd = txn.addr[0] ^ txn.size[0];

    assign tail_mask = ((txn.remaining <= SIZE_WIDTH'(2)) && tail_odd) ? 2'b10 : 2'b00;

    assign write_beat = txn.beat & ~txn.rw;

    ////////////////////////////////////////////////////////////////////////////
    // mask register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
            data_mask_o <= '0;
        else if (txn.idle)
            data_mask_o <= '0;
        else if (txn.setup)
            data_mask_o <= head_mask;   // first beat
        else if (write_beat)
            data_mask_o <= tail_mask;   // uses the count before decrement
    end

endmodule

//--- hyper_ctrl.sv
// top level of the hyperbus transaction controller
`timescale 1ns/1ps

module hyper_ctrl
(
    input  logic                                        clk_i,
    input  logic                                        rst_ni,

    // request port
    input  logic                                        trans_valid_i,
    output logic                                        trans_ready_o,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       size_i,
    input  logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       addr_i,
    input  logic                                        rw_i,          // 1: read
    input  logic                                        addr_space_i,
    input  logic [hyper_ctrl_pkg::MEM_SEL_WIDTH-1:0]    mem_sel_i,
    input  logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   t_rw_recovery_i,

    // phy port
    output logic                                        phy_trans_valid_o,
    input  logic                                        phy_trans_ready_i,
    input  logic                                        rx_valid_phy_i,
    input  logic                                        rx_ready_phy_i,
    input  logic                                        tx_valid_phy_i,
    input  logic                                        tx_ready_phy_i,

    // captured request
    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       ctrl_size_o,
    output logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       ctrl_addr_o,
    output logic                                        ctrl_rw_o,
    output logic                                        ctrl_addr_space_o,
    output logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   ctrl_t_rw_recovery_o,

    // status
    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       trans_burst_o,
    output logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       remained_data_o,
    output logic [hyper_ctrl_pkg::MASK_WIDTH-1:0]       data_mask_o,
    output logic [hyper_ctrl_pkg::NR_CS-1:0]            trans_cs_o,
    output logic                                        odd_start_o
);

    hyper_txn_if txn ();

    hyper_txn_fsm i_fsm (
        .clk_i                (clk_i),
        .rst_ni               (rst_ni),
        .trans_valid_i        (trans_valid_i),
        .trans_ready_o        (trans_ready_o),
        .size_i               (size_i),
        .addr_i               (addr_i),
        .rw_i                 (rw_i),
        .addr_space_i         (addr_space_i),
        .mem_sel_i            (mem_sel_i),
        .t_rw_recovery_i      (t_rw_recovery_i),
        .phy_trans_valid_o    (phy_trans_valid_o),
        .phy_trans_ready_i    (phy_trans_ready_i),
        .ctrl_size_o          (ctrl_size_o),
        .ctrl_addr_o          (ctrl_addr_o),
        .ctrl_rw_o            (ctrl_rw_o),
        .ctrl_addr_space_o    (ctrl_addr_space_o),
        .ctrl_t_rw_recovery_o (ctrl_t_rw_recovery_o),
        .trans_cs_o           (trans_cs_o),
        .txn                  (txn.fsm_mp)
    );

    hyper_beat_counter i_beat_counter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .rx_valid_phy_i  (rx_valid_phy_i),
        .rx_ready_phy_i  (rx_ready_phy_i),
        .tx_valid_phy_i  (tx_valid_phy_i),
        .tx_ready_phy_i  (tx_ready_phy_i),
        .trans_burst_o   (trans_burst_o),
        .remained_data_o (remained_data_o),
        .odd_start_o     (odd_start_o),
        .txn             (txn.counter_mp)
    );

    hyper_mask_gen i_mask_gen (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .data_mask_o (data_mask_o),
        .txn         (txn.mask_mp)
    );

endmodule

//--- hyper_ctrl_assert.sv
// concurrent checks of handshakes, captured request, beat counts, byte masks and chip select
`timescale 1ns/1ps

module hyper_ctrl_assert
(
    input  logic                                        clk_i,
    input  logic                                        rst_ni,
    input  logic                                        trans_valid_i,
    input  logic                                        trans_ready_o,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       size_i,
    input  logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       addr_i,
    input  logic                                        rw_i,
    input  logic                                        addr_space_i,
    input  logic [hyper_ctrl_pkg::MEM_SEL_WIDTH-1:0]    mem_sel_i,
    input  logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   t_rw_recovery_i,
    input  logic                                        phy_trans_valid_o,
    input  logic                                        phy_trans_ready_i,
    input  logic                                        rx_valid_phy_i,
    input  logic                                        rx_ready_phy_i,
    input  logic                                        tx_valid_phy_i,
    input  logic                                        tx_ready_phy_i,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       ctrl_size_o,
    input  logic [hyper_ctrl_pkg::ADDR_WIDTH-1:0]       ctrl_addr_o,
    input  logic                                        ctrl_rw_o,
    input  logic                                        ctrl_addr_space_o,
    input  logic [hyper_ctrl_pkg::RECOVERY_WIDTH-1:0]   ctrl_t_rw_recovery_o,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       trans_burst_o,
    input  logic [hyper_ctrl_pkg::SIZE_WIDTH-1:0]       remained_data_o,
    input  logic [hyper_ctrl_pkg::MASK_WIDTH-1:0]       data_mask_o,
    input  logic [hyper_ctrl_pkg::NR_CS-1:0]            trans_cs_o,
    input  logic                                        odd_start_o
);
    import hyper_ctrl_pkg::*;

    int                        n_errors = 0; // failed checks so far
    logic                      accept;
    logic                      handover;
    logic                      beat;
    logic                      act;          // data phase after the handover
    logic                      handed_q;
    logic [SIZE_WIDTH-1:0]     size_q;
    logic [ADDR_WIDTH-1:0]     addr_q;
    logic                      rw_q;
    logic                      space_q;
    logic [RECOVERY_WIDTH-1:0] rec_q;
    logic [MEM_SEL_WIDTH-1:0]  mem_sel_q;
    logic [SIZE_WIDTH-1:0]     rem_q;        // remaining count of the previous cycle
    logic [MASK_WIDTH-1:0]     tail_q;
    logic [SIZE_WIDTH-1:0]     burst_exp;
    logic [MASK_WIDTH-1:0]     head_exp;
    logic [MASK_WIDTH-1:0]     tail_exp;
    logic [NR_CS-1:0]          cs_exp;
    logic [1:0]                low_sum;

    assign accept   = trans_valid_i & trans_ready_o;
    assign handover = phy_trans_valid_o & phy_trans_ready_i;
    assign beat     = rw_q ? (rx_valid_phy_i & rx_ready_phy_i)
                           : (tx_valid_phy_i & tx_ready_phy_i);
    assign act      = handed_q & phy_trans_valid_o;

    // beats span the bytes from the start address, rounded up to whole beats
    assign burst_exp = (space_q && !rw_q) ? '0 :
        SIZE_WIDTH'((17'(size_q) + 17'(addr_q[0]) + 17'd1) >> 1);

    assign head_exp = addr_q[0] ? 2'b01 : (size_q == SIZE_WIDTH'(1)) ? 2'b10 : 2'b00;
    assign low_sum  = addr_q[1:0] + size_q[1:0];
    assign tail_exp = ((remained_data_o <= SIZE_WIDTH'(2)) && low_sum[0]) ? 2'b10 : 2'b00;
    assign cs_exp   = (mem_sel_q == MEM_SEL_FLASH) ? 2'b01 : 2'b10;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            handed_q  <= 1'b0;
            size_q    <= '0;
            addr_q    <= '0;
            rw_q      <= 1'b0;
            space_q   <= 1'b0;
            rec_q     <= T_RW_RECOVERY_RST;
            mem_sel_q <= '0;
            rem_q     <= '0;
            tail_q    <= '0;
        end
        else
        begin
            handed_q <= phy_trans_valid_o & (handed_q | phy_trans_ready_i);
            rem_q    <= remained_data_o;
            tail_q   <= tail_exp;
            if (accept) // request as taken on the handshake
            begin
                size_q    <= size_i;
                addr_q    <= addr_i;
                rw_q      <= rw_i;
                space_q   <= addr_space_i;
                rec_q     <= t_rw_recovery_i;
                mem_sel_q <= mem_sel_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request and phy handshakes
    ////////////////////////////////////////////////////////////////////////////

    a_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> (trans_ready_o &&
        !phy_trans_valid_o && trans_burst_o == '0 && remained_data_o == '0 && data_mask_o == '0))
    else
    begin
        n_errors++;
        $error("** Error: %0t outputs not at reset values after reset", $time);
    end

    a_ready_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
        accept |=> !trans_ready_o)
    else
    begin
        n_errors++;
        $error("** Error: %0t trans_ready_o got 1, expected 0", $time);
    end

    a_valid_second: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $past(accept, 2) |-> (!trans_ready_o && phy_trans_valid_o))
    else
    begin
        n_errors++;
        $error("** Error: %0t trans_ready_o %0b phy_trans_valid_o %0b, expected 0 and 1",
               $time, $sampled(trans_ready_o), $sampled(phy_trans_valid_o));
    end

    ////////////////////////////////////////////////////////////////////////////
    // captured request
    ////////////////////////////////////////////////////////////////////////////

    a_ctrl_size: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctrl_size_o == size_q)
    else
    begin
        n_errors++;
        $error("** Error: %0t ctrl_size_o got %0d, expected %0d",
               $time, $sampled(ctrl_size_o), $sampled(size_q));
    end

    a_ctrl_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctrl_addr_o == addr_q && odd_start_o == addr_q[0])
    else
    begin
        n_errors++;
        $error("** Error: %0t ctrl_addr_o %08h odd_start_o %0b, expected %08h %0b",
               $time, $sampled(ctrl_addr_o), $sampled(odd_start_o),
               $sampled(addr_q), $sampled(addr_q[0]));
    end

    a_ctrl_dir: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctrl_rw_o == rw_q && ctrl_addr_space_o == space_q)
    else
    begin
        n_errors++;
        $error("** Error: %0t ctrl_rw_o %0b ctrl_addr_space_o %0b, expected %0b %0b",
               $time, $sampled(ctrl_rw_o), $sampled(ctrl_addr_space_o),
               $sampled(rw_q), $sampled(space_q));
    end

    a_ctrl_recovery: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ctrl_t_rw_recovery_o == rec_q)
    else
    begin
        n_errors++;
        $error("** Error: %0t ctrl_t_rw_recovery_o got %0d, expected %0d",
               $time, $sampled(ctrl_t_rw_recovery_o), $sampled(rec_q));
    end

    ////////////////////////////////////////////////////////////////////////////
    // beat counts
    ////////////////////////////////////////////////////////////////////////////

    a_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
        handover |-> trans_burst_o == burst_exp)
    else
    begin
        n_errors++;
        $error("** Error: %0t trans_burst_o got %0d, expected %0d",
               $time, $sampled(trans_burst_o), $sampled(burst_exp));
    end

    a_decrement: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (act && beat && remained_data_o != '0) |=> remained_data_o == rem_q - SIZE_WIDTH'(1))
    else
    begin
        n_errors++;
        $error("** Error: %0t remained_data_o got %0d, expected %0d",
               $time, $sampled(remained_data_o), $sampled(rem_q) - SIZE_WIDTH'(1));
    end

    a_no_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (remained_data_o > rem_q) |-> (phy_trans_valid_o && !handed_q))
    else
    begin
        n_errors++;
        $error("** Error: %0t remained_data_o rose from %0d to %0d outside a handover",
               $time, $sampled(rem_q), $sampled(remained_data_o));
    end

    a_ready_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_ready_o |-> remained_data_o == '0)
    else
    begin
        n_errors++;
        $error("** Error: %0t remained_data_o got %0d, expected 0 while ready",
               $time, $sampled(remained_data_o));
    end

    ////////////////////////////////////////////////////////////////////////////
    // byte masks and chip select
    ////////////////////////////////////////////////////////////////////////////

    a_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (handover && !handed_q && !rw_q && !space_q) |=> data_mask_o == head_exp)
    else
    begin
        n_errors++;
        $error("** Error: %0t data_mask_o got %b, expected head %b",
               $time, $sampled(data_mask_o), $sampled(head_exp));
    end

    a_tail: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (act && beat && !rw_q && !space_q) |=> data_mask_o == tail_q)
    else
    begin
        n_errors++;
        $error("** Error: %0t data_mask_o got %b, expected tail %b",
               $time, $sampled(data_mask_o), $sampled(tail_q));
    end

    a_cs: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (trans_cs_o == cs_exp) && $onehot(trans_cs_o))
    else
    begin
        n_errors++;
        $error("** Error: %0t trans_cs_o got %b, expected %b",
               $time, $sampled(trans_cs_o), $sampled(cs_exp));
    end

endmodule

bind hyper_ctrl hyper_ctrl_assert u_checks (.*);

//--- tb_hyper_ctrl.sv
// testbench of the hyperbus transaction controller with random requests and phy back-pressure
`timescale 1ns/1ps

module tb_hyper_ctrl;
    import hyper_ctrl_pkg::*;

    localparam int N_TESTS    = 40;
    localparam int WAIT_LIMIT = 2000; // cycles per wait

    logic                      clk_i;
    logic                      rst_ni;
    logic                      trans_valid_i;
    logic                      trans_ready_o;
    logic [SIZE_WIDTH-1:0]     size_i;
    logic [ADDR_WIDTH-1:0]     addr_i;
    logic                      rw_i;
    logic                      addr_space_i;
    logic [MEM_SEL_WIDTH-1:0]  mem_sel_i;
    logic [RECOVERY_WIDTH-1:0] t_rw_recovery_i;
    logic                      phy_trans_valid_o;
    logic                      phy_trans_ready_i;
    logic                      rx_valid_phy_i;
    logic                      rx_ready_phy_i;
    logic                      tx_valid_phy_i;
    logic                      tx_ready_phy_i;
    logic [SIZE_WIDTH-1:0]     ctrl_size_o;
    logic [ADDR_WIDTH-1:0]     ctrl_addr_o;
    logic                      ctrl_rw_o;
    logic                      ctrl_addr_space_o;
    logic [RECOVERY_WIDTH-1:0] ctrl_t_rw_recovery_o;
    logic [SIZE_WIDTH-1:0]     trans_burst_o;
    logic [SIZE_WIDTH-1:0]     remained_data_o;
    logic [MASK_WIDTH-1:0]     data_mask_o;
    logic [NR_CS-1:0]          trans_cs_o;
    logic                      odd_start_o;

    int    n_passed;
    int    n_failed;
    int    errors_before;
    bit    ok;
    string kind;

    hyper_ctrl DUT (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // phy side stalls the handover and the beats at random
    task automatic shuffle_phy();
        phy_trans_ready_i = ($urandom_range(3, 0) != 0);
        rx_valid_phy_i    = 1'($urandom);
        rx_ready_phy_i    = 1'($urandom);
        tx_valid_phy_i    = 1'($urandom);
        tx_ready_phy_i    = 1'($urandom);
    endtask

    task automatic wait_for_ready(output bit found);
        found = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !found; n++)
        begin
            @(negedge clk_i);
            shuffle_phy();
            found = trans_ready_o;
        end
    endtask

    task automatic report_test(input int idx, input string what, input int errs, input bit done);
        if (!done)
        begin
            $display("test %0d %s: timeout, trans_ready_o did not return", idx, what);
            n_failed++;
        end
        else if (DUT.u_checks.n_errors != errs)
        begin
            $display("test %0d %s: FAILED with %0d assertion errors", idx, what,
                     DUT.u_checks.n_errors - errs);
            n_failed++;
        end
        else
        begin
            $display("test %0d %s: ok", idx, what);
            n_passed++;
        end
    endtask

    initial
    begin
        void'($urandom(32'hf8f87ff5));
        rst_ni            = 1'b0;
        trans_valid_i     = 1'b0;
        size_i            = '0;
        addr_i            = '0;
        rw_i              = 1'b0;
        addr_space_i      = 1'b0;
        mem_sel_i         = '0;
        t_rw_recovery_i   = '0;
        phy_trans_ready_i = 1'b0;
        rx_valid_phy_i    = 1'b0;
        rx_ready_phy_i    = 1'b0;
        tx_valid_phy_i    = 1'b0;
        tx_ready_phy_i    = 1'b0;
        n_passed          = 0;
        n_failed          = 0;

        repeat (8) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i); // reset values checked on the edge after release
        report_test(0, "reset", 0, 1'b1);

        for (int i = 1; i <= N_TESTS; i++)
        begin
            errors_before   = DUT.u_checks.n_errors;
            size_i          = SIZE_WIDTH'($urandom_range(9, 0));
            addr_i          = $urandom;
            rw_i            = 1'($urandom);
            addr_space_i    = !rw_i && ($urandom_range(3, 0) == 0); // occasional register write
            mem_sel_i       = MEM_SEL_WIDTH'($urandom);
            t_rw_recovery_i = RECOVERY_WIDTH'($urandom_range(4, 0));
            trans_valid_i   = 1'b1;   // trans_ready_o is high here
            kind = rw_i ? "read" : (addr_space_i ? "reg write" : "write");
            @(negedge clk_i);
            shuffle_phy();
            trans_valid_i = 1'b0;
            wait_for_ready(ok);
            report_test(i, $sformatf("%s size %0d addr %08h", kind, size_i, addr_i),
                        errors_before, ok);
            if (!ok)
                break;
        end

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 n_passed, n_failed, DUT.u_checks.n_errors);
        if (n_failed == 0 && DUT.u_checks.n_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- project.f
hyper_ctrl_pkg.sv
hyper_txn_if.sv
hyper_txn_fsm.sv
hyper_beat_counter.sv
hyper_mask_gen.sv
hyper_ctrl.sv
hyper_ctrl_assert.sv
tb_hyper_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 -f project.f --top-module tb_hyper_ctrl \
    --Mdir obj_dir -o sim_hyper_ctrl > build.log 2>&1 \
    && ./obj_dir/sim_hyper_ctrl +verilator+error+limit+1000 > sim.log 2>&1 \
    || cat build.log
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
